// ==== design/rv_dec_defs.svh ====
`ifndef RV_DEC_DEFS_SVH
`define RV_DEC_DEFS_SVH

//////////////////////////////////////////////////
// Core widths, fixed by the RV32I ISA
//////////////////////////////////////////////////

// Data and instruction word
`define RV_XLEN       32

// General-purpose register file
`define RV_NUM_REGS   32
`define RV_REG_AW     $clog2(`RV_NUM_REGS)

// ALU op code is {funct7[5], funct7[0], funct3}
`define RV_ALU_OP_W   5

// Retired instruction counter
`define RV_INSTRET_W  64

`endif

// ==== design/rv_dec_pkg.sv ====
`include "rv_dec_defs.svh"

package rv_dec_pkg;

    //////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [`RV_ALU_OP_W-1:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b10000,
        ALU_SLL  = 5'b00001,
        ALU_SLT  = 5'b00010,
        ALU_SLTU = 5'b00011,
        ALU_XOR  = 5'b00100,
        ALU_SRL  = 5'b00101,
        ALU_SRA  = 5'b10101,
        ALU_OR   = 5'b00110,
        ALU_AND  = 5'b00111
    } alu_op_e;

    //////////////////////////////////////////////////
    // Datapath mux selects
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        A_RS1 = 2'b00,  // Register read 1
        A_PC  = 2'b01   // Program counter
    } alu_a_sel_e;

    typedef enum logic [1:0] {
        B_RS2 = 2'b00,  // Register read 2
        B_IMM = 2'b01   // Decoded immediate
    } alu_b_sel_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'b00,
        WB_DMEM = 2'b01,
        WB_LINK = 2'b10  // PC+4
    } wb_sel_e;

    typedef enum logic {
        BR_ALU    = 1'b0,  // Target from ALU result
        BR_PC_IMM = 1'b1   // Target from PC+imm adder
    } br_sel_e;

    typedef enum logic [2:0] {
        IMM_I     = 3'd0,
        IMM_S     = 3'd1,
        IMM_B     = 3'd2,
        IMM_U     = 3'd3,
        IMM_J     = 3'd4,
        IMM_SHAMT = 3'd5,
        IMM_NONE  = 3'd7
    } imm_fmt_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_DMEM,
        ST_JUMP
    } dec_state_e;

endpackage

// ==== design/rv_imm_gen.sv ====
`include "rv_dec_defs.svh"

module rv_imm_gen (
    input  logic [`RV_XLEN-1:0]  instr_i,
    input  rv_dec_pkg::imm_fmt_e imm_fmt_i,
    output logic [`RV_XLEN-1:0]  imm_o
);

    logic sign;

    assign sign = instr_i[31];  // All signed formats extend from bit 31

    always_comb begin
        case (imm_fmt_i)
            rv_dec_pkg::IMM_I: begin
                imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:20]};
            end
            rv_dec_pkg::IMM_S: begin
                imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_dec_pkg::IMM_B: begin
                imm_o = {{(`RV_XLEN-13){sign}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};  // Halfword offset
            end
            rv_dec_pkg::IMM_U: begin
                imm_o = {instr_i[31:12], 12'h000};
            end
            rv_dec_pkg::IMM_J: begin
                imm_o = {{(`RV_XLEN-21){sign}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            rv_dec_pkg::IMM_SHAMT: begin
                imm_o = {{(`RV_XLEN-5){1'b0}}, instr_i[24:20]};  // Zero-extended
            end
            default: begin
                imm_o = '0;  // No immediate
            end
        endcase
    end

endmodule

// ==== design/rv_op_decode.sv ====
`include "rv_dec_defs.svh"

module rv_op_decode (
    input  logic [`RV_XLEN-1:0]     instr_i,
    input  logic                    flag_zero_i,
    // Immediate format for the generator
    output rv_dec_pkg::imm_fmt_e    imm_fmt_o,
    // ALU
    output rv_dec_pkg::alu_a_sel_e  alu_a_sel_o,
    output rv_dec_pkg::alu_b_sel_e  alu_b_sel_o,
    output rv_dec_pkg::alu_op_e     alu_op_sel_o,
    // Register file
    output logic [`RV_REG_AW-1:0]   rf_read1_addr_o,
    output logic [`RV_REG_AW-1:0]   rf_read2_addr_o,
    output logic [`RV_REG_AW-1:0]   rf_write_addr_o,
    output rv_dec_pkg::wb_sel_e     rf_write_sel_o,
    // Branch and load/store
    output rv_dec_pkg::br_sel_e     br_sel_o,
    output logic [2:0]              ls_ext_sel_o,
    // Flags for the sequencer
    output logic                    jump_taken_o,
    output logic                    rf_wb_req_o,
    output logic                    mem_access_o,
    output logic                    mem_write_o
);

    rv_dec_pkg::opcode_e          opcode;
    logic [2:0]                   funct3;
    logic [`RV_REG_AW-1:0]        rd;
    logic [`RV_REG_AW-1:0]        rs1;
    logic [`RV_REG_AW-1:0]        rs2;
    logic [`RV_ALU_OP_W-1:0]      alu_fn;

    assign opcode = rv_dec_pkg::opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];
    assign rs2    = instr_i[24:20];
    assign alu_fn = {instr_i[30], instr_i[25], funct3};  // Same layout as alu_op_e

    always_comb begin
        // Defaults match an unknown opcode
        imm_fmt_o       = rv_dec_pkg::IMM_NONE;
        alu_a_sel_o     = rv_dec_pkg::A_RS1;
        alu_b_sel_o     = rv_dec_pkg::B_RS2;
        alu_op_sel_o    = rv_dec_pkg::ALU_ADD;
        rf_read1_addr_o = '0;
        rf_read2_addr_o = '0;
        rf_write_addr_o = '0;
        rf_write_sel_o  = rv_dec_pkg::WB_ALU;
        br_sel_o        = rv_dec_pkg::BR_ALU;
        ls_ext_sel_o    = '0;
        jump_taken_o    = 1'b0;
        rf_wb_req_o     = 1'b0;
        mem_access_o    = 1'b0;
        mem_write_o     = 1'b0;

        case (opcode)
            rv_dec_pkg::OP_LUI: begin
                imm_fmt_o       = rv_dec_pkg::IMM_U;
                alu_b_sel_o     = rv_dec_pkg::B_IMM;  // x0 + imm
                rf_write_addr_o = rd;
                rf_wb_req_o     = 1'b1;
            end
            rv_dec_pkg::OP_AUIPC: begin
                imm_fmt_o       = rv_dec_pkg::IMM_U;
                alu_a_sel_o     = rv_dec_pkg::A_PC;
                alu_b_sel_o     = rv_dec_pkg::B_IMM;
                rf_write_addr_o = rd;
                rf_wb_req_o     = 1'b1;
            end
            rv_dec_pkg::OP_JAL: begin
                imm_fmt_o       = rv_dec_pkg::IMM_J;
                alu_a_sel_o     = rv_dec_pkg::A_PC;   // PC + offset
                alu_b_sel_o     = rv_dec_pkg::B_IMM;
                rf_write_addr_o = rd;
                rf_write_sel_o  = rv_dec_pkg::WB_LINK;
                jump_taken_o    = 1'b1;
                rf_wb_req_o     = 1'b1;
            end
            rv_dec_pkg::OP_JALR: begin
                imm_fmt_o       = rv_dec_pkg::IMM_I;
                alu_b_sel_o     = rv_dec_pkg::B_IMM;  // rs1 + offset
                rf_read1_addr_o = rs1;
                rf_write_addr_o = rd;
                rf_write_sel_o  = rv_dec_pkg::WB_LINK;
                jump_taken_o    = 1'b1;
                rf_wb_req_o     = 1'b1;
            end
            rv_dec_pkg::OP_BRANCH: begin
                imm_fmt_o       = rv_dec_pkg::IMM_B;
                rf_read1_addr_o = rs1;
                rf_read2_addr_o = rs2;
                br_sel_o        = rv_dec_pkg::BR_PC_IMM;
                // Compare in the ALU, then read the zero flag
                case (funct3)
                    3'b000: begin  // BEQ
                        alu_op_sel_o = rv_dec_pkg::ALU_SUB;
                        jump_taken_o = flag_zero_i;
                    end
                    3'b001: begin  // BNE
                        alu_op_sel_o = rv_dec_pkg::ALU_SUB;
                        jump_taken_o = !flag_zero_i;
                    end
                    3'b100,
                    3'b101: begin  // BLT, BGE
                        alu_op_sel_o = rv_dec_pkg::ALU_SLT;
                        jump_taken_o = funct3[0] ? flag_zero_i : !flag_zero_i;
                    end
                    3'b110,
                    3'b111: begin  // BLTU, BGEU
                        alu_op_sel_o = rv_dec_pkg::ALU_SLTU;
                        jump_taken_o = funct3[0] ? flag_zero_i : !flag_zero_i;
                    end
                    default: begin
                        jump_taken_o = 1'b0;  // Reserved funct3
                    end
                endcase
            end
            rv_dec_pkg::OP_LOAD: begin
                imm_fmt_o       = rv_dec_pkg::IMM_I;
                alu_b_sel_o     = rv_dec_pkg::B_IMM;
                rf_read1_addr_o = rs1;
                rf_write_addr_o = rd;
                rf_write_sel_o  = rv_dec_pkg::WB_DMEM;
                ls_ext_sel_o    = funct3;  // Width and sign of the load
                rf_wb_req_o     = 1'b1;
                mem_access_o    = 1'b1;
            end
            rv_dec_pkg::OP_STORE: begin
                imm_fmt_o       = rv_dec_pkg::IMM_S;
                alu_b_sel_o     = rv_dec_pkg::B_IMM;
                rf_read1_addr_o = rs1;
                rf_read2_addr_o = rs2;     // Store data
                ls_ext_sel_o    = funct3;
                mem_access_o    = 1'b1;
                mem_write_o     = 1'b1;
            end
            rv_dec_pkg::OP_IMM: begin
                alu_b_sel_o     = rv_dec_pkg::B_IMM;
                rf_read1_addr_o = rs1;
                rf_write_addr_o = rd;
                rf_wb_req_o     = 1'b1;
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_fmt_o    = rv_dec_pkg::IMM_SHAMT;
                    alu_op_sel_o = rv_dec_pkg::alu_op_e'(alu_fn);  // SRAI keeps bit 30
                end else begin
                    imm_fmt_o    = rv_dec_pkg::IMM_I;
                    alu_op_sel_o = rv_dec_pkg::alu_op_e'({2'b00, funct3});
                end
            end
            rv_dec_pkg::OP_REG: begin
                alu_op_sel_o    = rv_dec_pkg::alu_op_e'(alu_fn);
                rf_read1_addr_o = rs1;
                rf_read2_addr_o = rs2;
                rf_write_addr_o = rd;
                rf_wb_req_o     = 1'b1;
            end
            default: begin
                rf_wb_req_o     = 1'b0;  // Unknown opcode, nothing happens
            end
        endcase
    end

endmodule

// ==== design/rv_ctrl_fsm.sv ====
`include "rv_dec_defs.svh"

module rv_ctrl_fsm (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Memory handshakes
    input  logic                      imem_ready_i,
    input  logic                      dmem_ready_i,
    // Decoded flags
    input  logic                      jump_taken_i,
    input  logic                      rf_wb_req_i,
    input  logic                      mem_access_i,
    input  logic                      mem_write_i,
    // Enables to the datapath
    output logic                      imem_read_o,
    output logic                      pc_en_o,
    output logic                      iaddr_en_o,
    output logic                      pc_br_en_o,
    output logic                      rf_write_en_o,
    output logic                      dmem_req_o,
    output logic                      dmem_write_o,
    output logic [`RV_INSTRET_W-1:0]  instret_o
);

    rv_dec_pkg::dec_state_e state_q;
    rv_dec_pkg::dec_state_e state_d;
    logic                   retire;

    //////////////////////////////////////////////////
    // Next state and Mealy enables
    //////////////////////////////////////////////////

    always_comb begin
        state_d       = state_q;
        imem_read_o   = 1'b0;
        pc_en_o       = 1'b0;
        iaddr_en_o    = 1'b0;
        pc_br_en_o    = 1'b0;
        rf_write_en_o = 1'b0;
        dmem_req_o    = 1'b0;
        dmem_write_o  = 1'b0;

        unique case (state_q)
            rv_dec_pkg::ST_FETCH: begin
                state_d     = imem_ready_i ? rv_dec_pkg::ST_EXECUTE : rv_dec_pkg::ST_FETCH;
                imem_read_o = !imem_ready_i;  // Held until the word arrives
                pc_en_o     = imem_ready_i;
                iaddr_en_o  = imem_ready_i;
            end
            rv_dec_pkg::ST_EXECUTE: begin
                if (mem_access_i) begin
                    state_d = rv_dec_pkg::ST_DMEM;
                end else if (jump_taken_i) begin
                    state_d = rv_dec_pkg::ST_JUMP;
                end else begin
                    state_d = rv_dec_pkg::ST_FETCH;
                end
                imem_read_o   = !mem_access_i && !jump_taken_i;
                pc_en_o       = jump_taken_i;
                pc_br_en_o    = jump_taken_i;
                rf_write_en_o = rf_wb_req_i && !mem_access_i;  // Loads write back later
                dmem_req_o    = mem_access_i;
                dmem_write_o  = mem_access_i && mem_write_i;
            end
            rv_dec_pkg::ST_DMEM: begin
                state_d       = dmem_ready_i ? rv_dec_pkg::ST_FETCH : rv_dec_pkg::ST_DMEM;
                imem_read_o   = dmem_ready_i;
                rf_write_en_o = dmem_ready_i && rf_wb_req_i;
                dmem_req_o    = !dmem_ready_i;  // Drops in the ready cycle
                dmem_write_o  = !dmem_ready_i && mem_write_i;
            end
            rv_dec_pkg::ST_JUMP: begin
                // Branch target settles into the PC
                state_d     = rv_dec_pkg::ST_FETCH;
                imem_read_o = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rv_dec_pkg::ST_FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////
    // Retirement counter
    //////////////////////////////////////////////////

    assign retire = (state_q != rv_dec_pkg::ST_FETCH) && (state_d == rv_dec_pkg::ST_FETCH);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            instret_o <= '0;
        end else if (retire) begin
            instret_o <= instret_o + 1'b1;
        end
    end

endmodule

// ==== design/rv_decoder.sv ====
`include "rv_dec_defs.svh"

module rv_decoder (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    // Program counter
    output logic                      pc_en_o,
    output logic                      iaddr_en_o,
    // Instruction memory
    input  logic                      imem_ready_i,
    input  logic [`RV_XLEN-1:0]       imem_rdata_i,
    output logic                      imem_read_o,
    // Branch
    output rv_dec_pkg::br_sel_e       br_sel_o,
    output logic                      pc_br_en_o,
    // ALU
    output logic [`RV_XLEN-1:0]       alu_b_imm_o,
    output rv_dec_pkg::alu_a_sel_e    alu_a_sel_o,
    output rv_dec_pkg::alu_b_sel_e    alu_b_sel_o,
    output rv_dec_pkg::alu_op_e       alu_op_sel_o,
    input  logic                      flag_zero_i,
    // Load/store extension
    output logic [2:0]                ls_ext_sel_o,
    // Register file
    output rv_dec_pkg::wb_sel_e       rf_write_sel_o,
    output logic [`RV_REG_AW-1:0]     rf_write_addr_o,
    output logic                      rf_write_en_o,
    output logic [`RV_REG_AW-1:0]     rf_read1_addr_o,
    output logic [`RV_REG_AW-1:0]     rf_read2_addr_o,
    // Data memory
    input  logic                      dmem_ready_i,
    output logic                      dmem_req_o,
    output logic                      dmem_write_o,
    // Retired instructions
    output logic [`RV_INSTRET_W-1:0]  instret_o
);

    rv_dec_pkg::imm_fmt_e imm_fmt;
    logic                 jump_taken;  // Jump or taken branch
    logic                 rf_wb_req;
    logic                 mem_access;
    logic                 mem_write;

    rv_op_decode u_rv_op_decode (
        .instr_i         (imem_rdata_i),
        .flag_zero_i     (flag_zero_i),
        .imm_fmt_o       (imm_fmt),
        .alu_a_sel_o     (alu_a_sel_o),
        .alu_b_sel_o     (alu_b_sel_o),
        .alu_op_sel_o    (alu_op_sel_o),
        .rf_read1_addr_o (rf_read1_addr_o),
        .rf_read2_addr_o (rf_read2_addr_o),
        .rf_write_addr_o (rf_write_addr_o),
        .rf_write_sel_o  (rf_write_sel_o),
        .br_sel_o        (br_sel_o),
        .ls_ext_sel_o    (ls_ext_sel_o),
        .jump_taken_o    (jump_taken),
        .rf_wb_req_o     (rf_wb_req),
        .mem_access_o    (mem_access),
        .mem_write_o     (mem_write)
    );

    rv_imm_gen u_rv_imm_gen (
        .instr_i   (imem_rdata_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (alu_b_imm_o)
    );

    rv_ctrl_fsm u_rv_ctrl_fsm (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .imem_ready_i  (imem_ready_i),
        .dmem_ready_i  (dmem_ready_i),
        .jump_taken_i  (jump_taken),
        .rf_wb_req_i   (rf_wb_req),
        .mem_access_i  (mem_access),
        .mem_write_i   (mem_write),
        .imem_read_o   (imem_read_o),
        .pc_en_o       (pc_en_o),
        .iaddr_en_o    (iaddr_en_o),
        .pc_br_en_o    (pc_br_en_o),
        .rf_write_en_o (rf_write_en_o),
        .dmem_req_o    (dmem_req_o),
        .dmem_write_o  (dmem_write_o),
        .instret_o     (instret_o)
    );

endmodule

// ==== verif/tb_rv_ref_model.svh ====
`ifndef TB_RV_REF_MODEL_SVH
`define TB_RV_REF_MODEL_SVH

//////////////////////////////////////////////////
// Reference predictions from instruction fields
//////////////////////////////////////////////////

function automatic logic [31:0] imm_value(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_LUI,
        rv_dec_pkg::OP_AUIPC:  imm_value = {w[31:12], 12'h000};
        rv_dec_pkg::OP_JAL:    imm_value = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        rv_dec_pkg::OP_JALR,
        rv_dec_pkg::OP_LOAD:   imm_value = {{21{w[31]}}, w[30:20]};
        rv_dec_pkg::OP_STORE:  imm_value = {{21{w[31]}}, w[30:25], w[11:7]};
        rv_dec_pkg::OP_BRANCH: imm_value = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        rv_dec_pkg::OP_IMM:    imm_value = (w[13:12] == 2'b01) ? {27'h0, w[24:20]}
                                                               : {{21{w[31]}}, w[30:20]};
        default:               imm_value = 32'h0;
    endcase
endfunction

function automatic logic [4:0] alu_op_for(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_BRANCH: alu_op_for = !w[14] ? 5'b10000 : {4'b0001, w[13]};
        rv_dec_pkg::OP_IMM:    alu_op_for = (w[13:12] == 2'b01) ? {w[30], w[25], w[14:12]}
                                                                : {2'b00, w[14:12]};
        rv_dec_pkg::OP_REG:    alu_op_for = {w[30], w[25], w[14:12]};
        default:               alu_op_for = 5'b00000;  // Address and link adds
    endcase
endfunction

function automatic logic [1:0] wb_source(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_JAL,
        rv_dec_pkg::OP_JALR: wb_source = 2'd2;  // PC+4
        rv_dec_pkg::OP_LOAD: wb_source = 2'd1;
        default:             wb_source = 2'd0;
    endcase
endfunction

function automatic logic [1:0] a_source(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_AUIPC,
        rv_dec_pkg::OP_JAL: a_source = 2'd1;  // Program counter
        default:            a_source = 2'd0;
    endcase
endfunction

function automatic logic [1:0] b_source(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_LUI, rv_dec_pkg::OP_AUIPC, rv_dec_pkg::OP_JAL, rv_dec_pkg::OP_JALR,
        rv_dec_pkg::OP_LOAD, rv_dec_pkg::OP_STORE, rv_dec_pkg::OP_IMM: b_source = 2'd1;
        default:                                                       b_source = 2'd0;
    endcase
endfunction

function automatic logic br_source(input logic [31:0] w);
    // Conditional branches use the PC+imm adder
    br_source = (w[6:0] == rv_dec_pkg::OP_BRANCH);
endfunction

function automatic logic takes_jump(input logic [31:0] w, input logic fz);
    case (w[6:0])
        rv_dec_pkg::OP_JAL,
        rv_dec_pkg::OP_JALR:   takes_jump = 1'b1;
        // BEQ, BGE and BGEU are taken on zero
        rv_dec_pkg::OP_BRANCH: takes_jump = ((w[14:12] == 3'b000) || (w[14] && w[12])) ? fz : !fz;
        default:               takes_jump = 1'b0;
    endcase
endfunction

function automatic logic writes_reg(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_LUI, rv_dec_pkg::OP_AUIPC, rv_dec_pkg::OP_JAL, rv_dec_pkg::OP_JALR,
        rv_dec_pkg::OP_LOAD, rv_dec_pkg::OP_IMM, rv_dec_pkg::OP_REG: writes_reg = 1'b1;
        default:                                                     writes_reg = 1'b0;
    endcase
endfunction

function automatic logic accesses_mem(input logic [31:0] w);
    accesses_mem = (w[6:0] == rv_dec_pkg::OP_LOAD) || (w[6:0] == rv_dec_pkg::OP_STORE);
endfunction

function automatic logic [4:0] src1_addr(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_JALR, rv_dec_pkg::OP_BRANCH, rv_dec_pkg::OP_LOAD,
        rv_dec_pkg::OP_STORE, rv_dec_pkg::OP_IMM, rv_dec_pkg::OP_REG: src1_addr = w[19:15];
        default:                                                      src1_addr = 5'd0;
    endcase
endfunction

function automatic logic [4:0] src2_addr(input logic [31:0] w);
    case (w[6:0])
        rv_dec_pkg::OP_BRANCH, rv_dec_pkg::OP_STORE, rv_dec_pkg::OP_REG: src2_addr = w[24:20];
        default:                                                         src2_addr = 5'd0;
    endcase
endfunction

function automatic logic [4:0] dst_addr(input logic [31:0] w);
    dst_addr = writes_reg(w) ? w[11:7] : 5'd0;
endfunction

`endif

// ==== verif/tb_rv_decoder.sv ====
`include "rv_dec_defs.svh"

module tb_rv_decoder;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 4;
    localparam int RESET_CYCLES     = 4;
    localparam int N_PER_TEST       = 40;
    localparam int CYCLES_PER_INSTR = 15;  // Fetch 6, execute 1, dmem 6, margin
    localparam int CYCLE_LIMIT      = 5 * N_PER_TEST * CYCLES_PER_INSTR;

    logic                     clk_i = 1'b0;
    logic                     arst_n_i;
    logic                     imem_ready_i;
    logic [`RV_XLEN-1:0]      imem_rdata_i;
    logic                     flag_zero_i;
    logic                     dmem_ready_i;
    logic                     imem_read_o;
    logic                     pc_en_o;
    logic                     iaddr_en_o;
    logic                     pc_br_en_o;
    logic                     rf_write_en_o;
    logic                     dmem_req_o;
    logic                     dmem_write_o;
    rv_dec_pkg::br_sel_e      br_sel_o;
    rv_dec_pkg::alu_a_sel_e   alu_a_sel_o;
    rv_dec_pkg::alu_b_sel_e   alu_b_sel_o;
    rv_dec_pkg::alu_op_e      alu_op_sel_o;
    rv_dec_pkg::wb_sel_e      rf_write_sel_o;
    logic [`RV_XLEN-1:0]      alu_b_imm_o;
    logic [2:0]               ls_ext_sel_o;
    logic [`RV_REG_AW-1:0]    rf_write_addr_o;
    logic [`RV_REG_AW-1:0]    rf_read1_addr_o;
    logic [`RV_REG_AW-1:0]    rf_read2_addr_o;
    logic [`RV_INSTRET_W-1:0] instret_o;

    integer                   seed = 61033;
    int                       err_cnt = 0;
    int                       tests_passed = 0;
    int                       tests_failed = 0;
    int                       cycle_cnt = 0;
    int                       errs;
    logic [`RV_INSTRET_W-1:0] issued = '0;   // Instructions handed to the DUT
    logic [`RV_INSTRET_W-1:0] retired;       // Returns to fetch seen by the checker
    rv_dec_pkg::dec_state_e   exp_state;
    rv_dec_pkg::dec_state_e   next_state;
    logic                     mem_op;
    logic                     jump_op;

    `include "tb_rv_ref_model.svh"

    rv_decoder u_rv_decoder (.*);

    initial begin
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("ERR %s: expected %h, got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Checker with its own copy of the sequencing
    //////////////////////////////////////////////////

    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            compare("instret_o", 0, instret_o);
            compare("rf_write_en_o", 0, rf_write_en_o);
            compare("pc_br_en_o", 0, pc_br_en_o);
            compare("dmem_req_o", 0, dmem_req_o);
            compare("dmem_write_o", 0, dmem_write_o);
            exp_state <= rv_dec_pkg::ST_FETCH;
            retired   <= '0;
        end else begin
            next_state = rv_dec_pkg::ST_FETCH;
            mem_op     = accesses_mem(imem_rdata_i);
            jump_op    = takes_jump(imem_rdata_i, flag_zero_i);
            compare("instret_o", retired, instret_o);
            case (exp_state)
                rv_dec_pkg::ST_FETCH: begin
                    compare("imem_read_o", !imem_ready_i, imem_read_o);
                    compare("pc_en_o", imem_ready_i, pc_en_o);
                    compare("iaddr_en_o", imem_ready_i, iaddr_en_o);
                    compare("rf_write_en_o", 0, rf_write_en_o);
                    compare("pc_br_en_o", 0, pc_br_en_o);
                    compare("dmem_req_o", 0, dmem_req_o);
                    compare("dmem_write_o", 0, dmem_write_o);
                    next_state = imem_ready_i ? rv_dec_pkg::ST_EXECUTE : rv_dec_pkg::ST_FETCH;
                end
                rv_dec_pkg::ST_EXECUTE: begin
                    compare("alu_op_sel_o", alu_op_for(imem_rdata_i), alu_op_sel_o);
                    compare("alu_a_sel_o", a_source(imem_rdata_i), alu_a_sel_o);
                    compare("alu_b_sel_o", b_source(imem_rdata_i), alu_b_sel_o);
                    compare("br_sel_o", br_source(imem_rdata_i), br_sel_o);
                    compare("alu_b_imm_o", imm_value(imem_rdata_i), alu_b_imm_o);
                    compare("rf_read1_addr_o", src1_addr(imem_rdata_i), rf_read1_addr_o);
                    compare("rf_read2_addr_o", src2_addr(imem_rdata_i), rf_read2_addr_o);
                    compare("rf_write_addr_o", dst_addr(imem_rdata_i), rf_write_addr_o);
                    compare("rf_write_sel_o", wb_source(imem_rdata_i), rf_write_sel_o);
                    compare("rf_write_en_o", writes_reg(imem_rdata_i) && !mem_op, rf_write_en_o);
                    compare("pc_br_en_o", jump_op, pc_br_en_o);
                    compare("pc_en_o", jump_op, pc_en_o);
                    compare("iaddr_en_o", 0, iaddr_en_o);
                    compare("dmem_req_o", mem_op, dmem_req_o);
                    compare("dmem_write_o", mem_op && !writes_reg(imem_rdata_i), dmem_write_o);
                    compare("imem_read_o", !mem_op && !jump_op, imem_read_o);
                    if (mem_op) begin
                        compare("ls_ext_sel_o", imem_rdata_i[14:12], ls_ext_sel_o);
                        next_state = rv_dec_pkg::ST_DMEM;
                    end else if (jump_op) begin
                        next_state = rv_dec_pkg::ST_JUMP;
                    end
                end
                rv_dec_pkg::ST_DMEM: begin
                    compare("dmem_req_o", !dmem_ready_i, dmem_req_o);
                    compare("dmem_write_o", !dmem_ready_i && !writes_reg(imem_rdata_i),
                            dmem_write_o);
                    compare("rf_write_en_o", dmem_ready_i && writes_reg(imem_rdata_i),
                            rf_write_en_o);
                    compare("imem_read_o", dmem_ready_i, imem_read_o);
                    compare("pc_en_o", 0, pc_en_o);
                    compare("iaddr_en_o", 0, iaddr_en_o);
                    compare("pc_br_en_o", 0, pc_br_en_o);
                    compare("ls_ext_sel_o", imem_rdata_i[14:12], ls_ext_sel_o);
                    next_state = dmem_ready_i ? rv_dec_pkg::ST_FETCH : rv_dec_pkg::ST_DMEM;
                end
                default: begin  // Jump settle
                    compare("imem_read_o", 1, imem_read_o);
                    compare("pc_en_o", 0, pc_en_o);
                    compare("iaddr_en_o", 0, iaddr_en_o);
                    compare("pc_br_en_o", 0, pc_br_en_o);
                    compare("rf_write_en_o", 0, rf_write_en_o);
                    compare("dmem_req_o", 0, dmem_req_o);
                    compare("dmem_write_o", 0, dmem_write_o);
                end
            endcase
            if (exp_state != rv_dec_pkg::ST_FETCH && next_state == rv_dec_pkg::ST_FETCH) begin
                retired <= retired + 1'b1;
            end
            exp_state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Kinds: 0 IMM, 1 REG, 2 LUI, 3 AUIPC, 4 JAL, 5 JALR, 6 BRANCH, 7 STORE, 8 LOAD
    task automatic random_word(input int kind, output logic [31:0] word);
        logic [2:0] f3;
        word = $random(seed);
        f3   = word[14:12];
        case (kind)
            0: begin
                word[6:0] = rv_dec_pkg::OP_IMM;
                if (f3 == 3'b001) begin
                    word[31:25] = 7'b0;
                end else if (f3 == 3'b101) begin
                    word[31:25] = {1'b0, word[30], 5'b0};  // SRLI or SRAI
                end
            end
            1: begin
                word[6:0]   = rv_dec_pkg::OP_REG;
                word[31:25] = (f3 == 3'b000 || f3 == 3'b101) ? {1'b0, word[30], 5'b0} : 7'b0;
            end
            2: word[6:0] = rv_dec_pkg::OP_LUI;
            3: word[6:0] = rv_dec_pkg::OP_AUIPC;
            4: word[6:0] = rv_dec_pkg::OP_JAL;
            5: word[6:0] = rv_dec_pkg::OP_JALR;
            6: begin
                word[6:0] = rv_dec_pkg::OP_BRANCH;
                if (f3[2:1] == 2'b01) begin
                    word[14] = 1'b1;  // Reserved codes become BLTU/BGEU
                end
            end
            7: word[6:0] = rv_dec_pkg::OP_STORE;
            default: word[6:0] = rv_dec_pkg::OP_LOAD;
        endcase
    endtask

    // Fetch one word, answer data memory, wait for retirement
    task automatic run_instr(input int kind);
        logic [31:0]              word;
        logic [31:0]              rnd;
        int                       delay;
        logic [`RV_INSTRET_W-1:0] target;
        random_word(kind, word);
        rnd          = $random(seed);
        target       = instret_o + 1'b1;
        imem_rdata_i = word;
        flag_zero_i  = rnd[0];
        delay        = {$random(seed)} % 6;
        repeat (delay) @(negedge clk_i);
        imem_ready_i = 1'b1;
        @(negedge clk_i);
        imem_ready_i = 1'b0;
        if (accesses_mem(word)) begin
            @(negedge clk_i);  // Execute done
            delay = {$random(seed)} % 6;
            repeat (delay) @(negedge clk_i);
            dmem_ready_i = 1'b1;
            @(negedge clk_i);
            dmem_ready_i = 1'b0;
        end
        while (instret_o != target) begin
            @(negedge clk_i);
        end
        issued++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("Test %s: passed", name);
            tests_passed++;
        end else begin
            $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
            tests_failed++;
        end
    endtask

    task automatic run_test(input string name, input int lo, input int hi);
        int errs_before;
        errs_before = err_cnt;
        repeat (N_PER_TEST) begin
            run_instr(lo + ({$random(seed)} % (hi - lo + 1)));
        end
        report_test(name, errs_before);
    endtask

    initial begin
        arst_n_i     = 1'b0;
        imem_ready_i = 1'b0;
        imem_rdata_i = '0;
        flag_zero_i  = 1'b0;
        dmem_ready_i = 1'b0;
        errs         = err_cnt;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        run_instr(1);  // First fetch after reset
        report_test("reset", errs);
        run_test("alu", 0, 1);
        run_test("immediates", 0, 7);
        run_test("branches and jumps", 4, 6);
        run_test("loads and stores", 7, 8);
        errs = err_cnt;
        compare("instret_o", issued, instret_o);
        compare("instret_o", retired, instret_o);
        report_test("retirement", errs);
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+design
+incdir+verif
design/rv_dec_pkg.sv
design/rv_imm_gen.sv
design/rv_op_decode.sv
design/rv_ctrl_fsm.sv
design/rv_decoder.sv
verif/tb_rv_decoder.sv

// ==== Bender.yml ====
package:
  name: rv_decoder

sources:
  - include_dirs:
      - design
    files:
      - design/rv_dec_pkg.sv
      - design/rv_imm_gen.sv
      - design/rv_op_decode.sv
      - design/rv_ctrl_fsm.sv
      - design/rv_decoder.sv
  - target: test
    include_dirs:
      - design
      - verif
    files:
      - verif/tb_rv_decoder.sv
